// File: vlog.f
hw/oled_link_pkg.sv
hw/oled_font_pkg.sv
hw/oled_frame_sequencer.sv
hw/oled_byte_fifo.sv
hw/oled_spi_shifter.sv
hw/oled_display_top.sv
verification/oled_display_tb.sv

// File: verification/oled_display_tb.sv
/*
 * Testbench for the OLED amplitude display. Decodes the serial link,
 * rebuilds every byte with its D/C level and compares it with the expected
 * init, clear and text stream, changing the amplitude between text passes.
 */
module oled_display_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_DIV    = 4;
	localparam int FIFO_DEPTH = 8;
	localparam int RESET_HOLD = 16;
	localparam int NUM_PASSES = 4;	// last pass carries a non-decimal digit
	localparam int ADDR_BYTES = oled_link_pkg::ADDR_CMD_COUNT;
	localparam int PAGE_BYTES = ADDR_BYTES + oled_link_pkg::PAGE_COLUMNS;
	localparam int SETUP_BYTES = oled_link_pkg::INIT_CMD_COUNT
		+ oled_link_pkg::PAGE_COUNT * PAGE_BYTES;
	localparam int PASS_BYTES = ADDR_BYTES
		+ oled_font_pkg::TEXT_GLYPHS * oled_font_pkg::GLYPH_COLS;
	localparam int EXP_TOTAL = SETUP_BYTES + NUM_PASSES * PASS_BYTES;
	localparam int WATCHDOG_CYCLES = 2 * (EXP_TOTAL * 9 * CLK_DIV + 1000);

	logic        clk_in;
	logic        rst_n_in;
	logic [19:0] amp_bcd;
	logic        oled_rst_n;
	logic        oled_cs_n;
	logic        oled_dc;
	logic        oled_sclk;
	logic        oled_sdata;

	logic [19:0] amp_list [NUM_PASSES];
	logic [8:0]  rx_q [$];	// {kind, byte} as seen on the wire
	logic [7:0]  shift_in;
	logic        dc_seen;
	logic        in_byte;
	logic        rst_pulse_done;
	int          bit_cnt;
	int          rx_count;
	int          compared;

	oled_display_top #(
		.CLK_DIV    (CLK_DIV),
		.FIFO_DEPTH (FIFO_DEPTH),
		.RESET_HOLD (RESET_HOLD)
	) uut (
		.clk_in     (clk_in),
		.rst_n_in   (rst_n_in),
		.amp_bcd    (amp_bcd),
		.oled_rst_n (oled_rst_n),
		.oled_cs_n  (oled_cs_n),
		.oled_dc    (oled_dc),
		.oled_sclk  (oled_sclk),
		.oled_sdata (oled_sdata)
	);

	always #4 clk_in = ~clk_in;

	task automatic stop_run(input string why);
		$display("%s (t=%0t)", why, $time);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			stop_run("mismatch on the panel link");
		end
	endtask

	function automatic logic [19:0] random_amplitude();
		logic [19:0] v;
		int d;
		for (d = 0; d < 5; d++)
			v[4*d +: 4] = 4'($urandom % 10);
		return v;
	endfunction

	// panel addressing uses Bx for the page and 0x, 1x for the column nibbles
	function automatic logic [7:0] position_cmd(input int page, input int col, input int k);
		logic [7:0] c;
		c = 8'(col);
		if (k == 0)
			return 8'hB0 | 8'(page);
		else if (k == 1)
			return c & 8'h0F;
		else
			return 8'h10 | (c >> 4);
	endfunction

	// "Vpp:" then five digits msd first then "mV"
	function automatic oled_font_pkg::glyph_code_t line_glyph(input int pos,
		input logic [19:0] amp);
		logic [3:0] nib;
		oled_font_pkg::glyph_code_t code;
		if (pos >= 4 && pos <= 8)
		begin
			nib = amp[4*(8-pos) +: 4];
			if (nib > 4'd9)
				code = oled_font_pkg::GLYPH_BLANK;
			else
				code = oled_font_pkg::glyph_code_t'(nib);
		end
		else if (pos == 0 || pos == 10)
			code = oled_font_pkg::GLYPH_V;
		else if (pos == 1 || pos == 2)
			code = oled_font_pkg::GLYPH_P_LOWER;
		else if (pos == 3)
			code = oled_font_pkg::GLYPH_COLON;
		else
			code = oled_font_pkg::GLYPH_M_LOWER;
		return code;
	endfunction

	// expected {kind, byte} at stream position n for text amplitude amp
	function automatic logic [8:0] expected_item(input int n, input logic [19:0] amp);
		oled_link_pkg::byte_kind_t kind;
		logic [7:0] val;
		oled_font_pkg::glyph_t g;
		oled_font_pkg::glyph_code_t code;
		int k;
		kind = oled_link_pkg::KIND_CMD;
		if (n < oled_link_pkg::INIT_CMD_COUNT)
			val = oled_link_pkg::init_cmd_byte(n);
		else if (n < SETUP_BYTES)
		begin
			k = (n - oled_link_pkg::INIT_CMD_COUNT) % PAGE_BYTES;
			if (k < ADDR_BYTES)
				val = position_cmd((n - oled_link_pkg::INIT_CMD_COUNT) / PAGE_BYTES, 0, k);
			else
			begin
				kind = oled_link_pkg::KIND_DATA;
				val  = 8'h00;	// cleared column
			end
		end
		else
		begin
			k = (n - SETUP_BYTES) % PASS_BYTES;
			if (k < ADDR_BYTES)
				val = position_cmd(oled_link_pkg::TEXT_PAGE, 1, k);	// text starts at column 1
			else
			begin
				k    = k - ADDR_BYTES;
				code = line_glyph(k / oled_font_pkg::GLYPH_COLS, amp);
				g    = oled_font_pkg::glyph_bits(code);
				kind = oled_link_pkg::KIND_DATA;
				if (code == oled_font_pkg::GLYPH_BLANK)
					val = 8'h00;	// blank cell is all dark
				else
					val = g[k % oled_font_pkg::GLYPH_COLS];
			end
		end
		return {kind, val};
	endfunction

	// link monitor
	always @(negedge oled_cs_n)
	begin
		if (!rst_pulse_done)
			stop_run("chip select fell before the panel reset pulse ended");
		else
		begin
			dc_seen = oled_dc;
			bit_cnt = 0;
			in_byte = 1'b1;
		end
	end

	always @(posedge oled_sclk)
	begin
		if (oled_cs_n === 1'b0)
		begin
			shift_in = {shift_in[6:0], oled_sdata};	// msb arrives first
			bit_cnt++;
			if (bit_cnt == 8)
			begin
				rx_q.push_back({dc_seen, shift_in});
				rx_count++;
			end
		end
	end

	always @(posedge oled_cs_n)
	begin
		if (in_byte && bit_cnt != 8)
			stop_run($sformatf("chip select rose after %0d bits instead of 8", bit_cnt));
		else
			in_byte = 1'b0;
	end

	// compare process
	initial
	begin
		logic [8:0] got;
		logic [8:0] exp;
		int pass_idx;
		while (compared < EXP_TOTAL)
		begin
			wait (rx_q.size() > 0);
			got = rx_q.pop_front();
			pass_idx = (compared < SETUP_BYTES) ? 0 : (compared - SETUP_BYTES) / PASS_BYTES;
			exp = expected_item(compared, amp_list[pass_idx]);
			check_value($sformatf("oled_sdata (byte %0d)", compared), got[7:0], exp[7:0]);
			check_value($sformatf("oled_dc (byte %0d)", compared), got[8], exp[8]);
			compared++;
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_in);
		stop_run("watchdog expired, the serial link stalled");
	end

	initial
	begin
		int p;
		int low_cycles;
		clk_in = 1'b0;
		rst_n_in = 1'b0;
		amp_bcd = '0;
		rst_pulse_done = 1'b0;
		in_byte = 1'b0;
		bit_cnt = 0;
		rx_count = 0;
		compared = 0;
		shift_in = '0;
		void'($urandom(30));
		for (p = 0; p < NUM_PASSES; p++)
			amp_list[p] = random_amplitude();
		amp_list[NUM_PASSES-1][4*($urandom % 5) +: 4] = 4'hF;	// shows as blank
		amp_bcd = amp_list[0];
		repeat (10) @(negedge clk_in);
		check_value("oled_cs_n", oled_cs_n, 1);
		check_value("oled_rst_n", oled_rst_n, 1);
		check_value("oled_sclk", oled_sclk, 1);
		check_value("oled_sdata", oled_sdata, 0);
		rst_n_in = 1'b1;

		low_cycles = 0;
		while (!(low_cycles > 0 && oled_rst_n === 1'b1))
		begin
			@(negedge clk_in);
			if (oled_rst_n === 1'b0)
				low_cycles++;
		end
		rst_pulse_done = 1'b1;
		check_value("oled_rst_n low cycles", low_cycles, RESET_HOLD);

		// next value goes in once 20 data bytes of the current pass are out
		for (p = 1; p < NUM_PASSES; p++)
		begin
			wait (rx_count >= SETUP_BYTES + (p - 1) * PASS_BYTES + ADDR_BYTES + 20);
			@(negedge clk_in);
			amp_bcd = amp_list[p];
		end

		wait (compared >= EXP_TOTAL);
		@(negedge clk_in);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: hw/oled_display_top.sv
/*
 * OLED amplitude display top level. Chains the frame sequencer, the byte
 * FIFO and the serial shifter, and sets the parameters of each block.
 */
module oled_display_top #(
	parameter int CLK_DIV    = 20,	// sclk period in clk_in cycles
	parameter int FIFO_DEPTH = 8,
	parameter int RESET_HOLD = 16	// panel reset low time
) (
	input  logic        clk_in,
	input  logic        rst_n_in,
	input  logic [19:0] amp_bcd,	// five BCD digits, msd in [19:16]
	output logic        oled_rst_n,
	output logic        oled_cs_n,
	output logic        oled_dc,
	output logic        oled_sclk,
	output logic        oled_sdata
);

	logic [7:0]                wr_byte;
	oled_link_pkg::byte_kind_t wr_kind;
	logic                      wr_valid;
	logic                      wr_ready;
	logic [7:0]                rd_byte;
	oled_link_pkg::byte_kind_t rd_kind;
	logic                      rd_valid;
	logic                      rd_ready;

	oled_frame_sequencer #(
		.RESET_HOLD (RESET_HOLD)
	) u_sequencer (
		.clk_in     (clk_in),
		.rst_n_in   (rst_n_in),
		.amp_bcd    (amp_bcd),
		.wr_ready   (wr_ready),
		.wr_byte    (wr_byte),
		.wr_kind    (wr_kind),
		.wr_valid   (wr_valid),
		.oled_rst_n (oled_rst_n)
	);

	oled_byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_in   (clk_in),
		.rst_n_in (rst_n_in),
		.wr_byte  (wr_byte),
		.wr_kind  (wr_kind),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.rd_byte  (rd_byte),
		.rd_kind  (rd_kind),
		.rd_valid (rd_valid),
		.rd_ready (rd_ready)
	);

	oled_spi_shifter #(
		.CLK_DIV (CLK_DIV)
	) u_shifter (
		.clk_in     (clk_in),
		.rst_n_in   (rst_n_in),
		.rd_byte    (rd_byte),
		.rd_kind    (rd_kind),
		.rd_valid   (rd_valid),
		.rd_ready   (rd_ready),
		.oled_cs_n  (oled_cs_n),
		.oled_dc    (oled_dc),
		.oled_sclk  (oled_sclk),
		.oled_sdata (oled_sdata)
	);

endmodule

// File: hw/oled_spi_shifter.sv
/*
 * Serial shifter for the panel link. Takes one byte at a time from the FIFO
 * and sends it MSB first, sclk idle high, data changing on the falling edge.
 * CLK_DIV is the sclk period in clock cycles and must be at least 2.
 */
module oled_spi_shifter #(
	parameter int CLK_DIV = 20
) (
	input  logic                       clk_in,
	input  logic                       rst_n_in,
	input  logic [7:0]                 rd_byte,
	input  oled_link_pkg::byte_kind_t  rd_kind,
	input  logic                       rd_valid,
	output logic                       rd_ready,
	output logic                       oled_cs_n,
	output logic                       oled_dc,
	output logic                       oled_sclk,
	output logic                       oled_sdata
);

	localparam int DIV_W = $clog2(CLK_DIV);

	typedef enum logic [1:0] {
		SH_IDLE,	// waiting for a byte
		SH_SETUP,	// D/C set, waiting for the next fall strobe
		SH_SHIFT
	} shift_state_t;

	shift_state_t     state;
	logic [DIV_W-1:0] div_cnt;
	logic             fall_stb;
	logic             rise_stb;
	logic [7:0]       shift_reg;
	logic [2:0]       bit_cnt;

	assign fall_stb = (div_cnt == '0);
	assign rise_stb = (div_cnt == DIV_W'(CLK_DIV / 2));
	assign rd_ready = (state == SH_IDLE);

	// free-running divider, one strobe per sclk edge
	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
			div_cnt <= '0;
		else if (div_cnt == DIV_W'(CLK_DIV - 1))
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			state      <= SH_IDLE;
			shift_reg  <= '0;
			bit_cnt    <= '0;
			oled_cs_n  <= 1'b1;
			oled_dc    <= 1'b0;
			oled_sclk  <= 1'b1;
			oled_sdata <= 1'b0;
		end
		else
		begin
			case (state)
				SH_IDLE:
				begin
					if (rd_valid)
					begin
						shift_reg <= rd_byte;
						oled_dc   <= rd_kind;	// settles before cs falls
						state     <= SH_SETUP;
					end
				end
				SH_SETUP:
				begin
					if (fall_stb)
					begin
						oled_cs_n  <= 1'b0;
						oled_sclk  <= 1'b0;
						oled_sdata <= shift_reg[7];	// msb first
						bit_cnt    <= '0;
						state      <= SH_SHIFT;
					end
				end
				default:
				begin
					if (rise_stb)
						oled_sclk <= 1'b1;	// panel samples here
					else if (fall_stb)
					begin
						if (bit_cnt == 3'd7)
						begin
							oled_cs_n  <= 1'b1;	// sclk stays high
							oled_sdata <= 1'b0;
							state      <= SH_IDLE;
						end
						else
						begin
							oled_sclk  <= 1'b0;
							oled_sdata <= shift_reg[6];
							shift_reg  <= {shift_reg[6:0], 1'b0};
							bit_cnt    <= bit_cnt + 3'd1;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: hw/oled_byte_fifo.sv
/*
 * Circular byte buffer between the sequencer and the serial shifter.
 * Each entry carries its command/data kind. FIFO_DEPTH is a power of two.
 */
module oled_byte_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                       clk_in,
	input  logic                       rst_n_in,
	input  logic [7:0]                 wr_byte,
	input  oled_link_pkg::byte_kind_t  wr_kind,
	input  logic                       wr_valid,
	output logic                       wr_ready,
	output logic [7:0]                 rd_byte,
	output oled_link_pkg::byte_kind_t  rd_kind,
	output logic                       rd_valid,
	input  logic                       rd_ready
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [7:0]                mem_byte [FIFO_DEPTH];
	oled_link_pkg::byte_kind_t mem_kind [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;	// one extra bit to tell full from empty
	logic push;
	logic pop;

	assign wr_ready = (count != (PTR_W+1)'(FIFO_DEPTH));
	assign rd_valid = (count != '0);
	assign push = wr_valid & wr_ready;
	assign pop  = rd_valid & rd_ready;
	assign rd_byte = mem_byte[rd_ptr];	// head shown without a read cycle
	assign rd_kind = mem_kind[rd_ptr];

	always_ff @(posedge clk_in)
	begin
		if (push)
		begin
			mem_byte[wr_ptr] <= wr_byte;
			mem_kind[wr_ptr] <= wr_kind;
		end
	end

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: hw/oled_frame_sequencer.sv
/*
 * Byte producer for the panel. Pulses the panel reset, sends the init
 * table, clears every page, then repeats the amplitude text line forever.
 * Bytes leave over a valid/ready link and are held while the FIFO is full.
 */
module oled_frame_sequencer #(
	parameter int RESET_HOLD = 16
) (
	input  logic                       clk_in,
	input  logic                       rst_n_in,
	input  logic [19:0]                amp_bcd,
	input  logic                       wr_ready,
	output logic [7:0]                 wr_byte,
	output oled_link_pkg::byte_kind_t  wr_kind,
	output logic                       wr_valid,
	output logic                       oled_rst_n
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);
	localparam int IDX_W  = $clog2(oled_link_pkg::PAGE_COLUMNS);
	localparam int PAGE_W = $clog2(oled_link_pkg::PAGE_COUNT);
	localparam logic [7:0] TEXT_COL = 8'd1;	// text starts one column in

	oled_link_pkg::seq_state_t state;
	logic [HOLD_W-1:0] hold_cnt;
	logic [IDX_W-1:0]  byte_idx;	// init / addr / clear byte counter
	logic [PAGE_W-1:0] page_idx;
	logic [3:0]        glyph_pos;
	logic [2:0]        col_idx;
	logic [19:0]       amp_hold;	// amplitude frozen for one text pass
	oled_font_pkg::glyph_t cur_glyph;
	logic fire;
	logic clear_last;
	logic text_last;
	logic latch_amp;

	// position command bytes: page select, column low, column high
	function automatic logic [7:0] addr_cmd(input logic [3:0] page,
		input logic [7:0] col, input logic [1:0] idx);
		case (idx)
			2'd0:    addr_cmd = {4'hB, page};
			2'd1:    addr_cmd = {4'h0, col[3:0]};
			default: addr_cmd = {4'h1, col[7:4]};
		endcase
	endfunction

	assign fire = wr_valid & wr_ready;
	assign clear_last = (state == oled_link_pkg::CLEAR_DATA)
		&& (byte_idx == IDX_W'(oled_link_pkg::PAGE_COLUMNS - 1))
		&& (page_idx == PAGE_W'(oled_link_pkg::PAGE_COUNT - 1));
	assign text_last = (state == oled_link_pkg::TEXT_DATA)
		&& (col_idx == 3'(oled_font_pkg::GLYPH_COLS - 1))
		&& (glyph_pos == 4'(oled_font_pkg::TEXT_GLYPHS - 1));
	assign latch_amp = fire & (clear_last | text_last);	// entering TEXT_ADDR
	assign cur_glyph = oled_font_pkg::glyph_bits(oled_font_pkg::text_glyph_at(glyph_pos,
		amp_hold));

	always_comb
	begin
		wr_valid = 1'b1;
		wr_kind  = oled_link_pkg::KIND_CMD;
		wr_byte  = 8'h00;
		case (state)
			oled_link_pkg::RESET_PULSE:
				wr_valid = 1'b0;	// nothing flows during panel reset
			oled_link_pkg::INIT_CMDS:
				wr_byte = oled_link_pkg::init_cmd_byte(int'(byte_idx));
			oled_link_pkg::CLEAR_ADDR:
				wr_byte = addr_cmd(4'(page_idx), 8'd0, byte_idx[1:0]);
			oled_link_pkg::CLEAR_DATA:
				wr_kind = oled_link_pkg::KIND_DATA;	// zero columns
			oled_link_pkg::TEXT_ADDR:
				wr_byte = addr_cmd(4'(oled_link_pkg::TEXT_PAGE), TEXT_COL, byte_idx[1:0]);
			default:
			begin
				wr_kind = oled_link_pkg::KIND_DATA;
				wr_byte = cur_glyph[col_idx];
			end
		endcase
	end

	always_ff @(posedge clk_in)
	begin
		if (latch_amp)
			amp_hold <= amp_bcd;
	end

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			state      <= oled_link_pkg::RESET_PULSE;
			hold_cnt   <= '0;
			byte_idx   <= '0;
			page_idx   <= '0;
			glyph_pos  <= '0;
			col_idx    <= '0;
			oled_rst_n <= 1'b1;
		end
		else
		begin
			case (state)
				oled_link_pkg::RESET_PULSE:
				begin
					hold_cnt   <= hold_cnt + 1'b1;
					oled_rst_n <= (hold_cnt == HOLD_W'(RESET_HOLD));	// low RESET_HOLD cycles
					if (hold_cnt == HOLD_W'(RESET_HOLD))
						state <= oled_link_pkg::INIT_CMDS;
				end
				oled_link_pkg::INIT_CMDS:
				begin
					if (fire)
					begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == IDX_W'(oled_link_pkg::INIT_CMD_COUNT - 1))
						begin
							byte_idx <= '0;
							state    <= oled_link_pkg::CLEAR_ADDR;
						end
					end
				end
				oled_link_pkg::CLEAR_ADDR, oled_link_pkg::TEXT_ADDR:
				begin
					if (fire)
					begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == IDX_W'(oled_link_pkg::ADDR_CMD_COUNT - 1))
						begin
							byte_idx <= '0;
							if (state == oled_link_pkg::CLEAR_ADDR)
								state <= oled_link_pkg::CLEAR_DATA;
							else
								state <= oled_link_pkg::TEXT_DATA;
						end
					end
				end
				oled_link_pkg::CLEAR_DATA:
				begin
					if (fire)
					begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == IDX_W'(oled_link_pkg::PAGE_COLUMNS - 1))
						begin
							byte_idx <= '0;
							page_idx <= page_idx + 1'b1;
							state    <= clear_last ? oled_link_pkg::TEXT_ADDR
								: oled_link_pkg::CLEAR_ADDR;
						end
					end
				end
				default:
				begin
					if (fire)
					begin
						col_idx <= col_idx + 3'd1;
						if (col_idx == 3'(oled_font_pkg::GLYPH_COLS - 1))
						begin
							col_idx   <= '0;
							glyph_pos <= text_last ? 4'd0 : glyph_pos + 4'd1;
							if (text_last)
								state <= oled_link_pkg::TEXT_ADDR;	// next pass
						end
					end
				end
			endcase
		end
	end

endmodule

// File: hw/oled_font_pkg.sv
/*
 * 6x8 font subset for the amplitude line. Column 0 of a glyph is sent
 * first; text_glyph_at maps a line position to the glyph shown there.
 */
package oled_font_pkg;

	localparam int GLYPH_COLS  = 6;
	localparam int TEXT_GLYPHS = 11;	// "Vpp:" + 5 digits + "mV"

	typedef logic [0:GLYPH_COLS-1][7:0] glyph_t;	// index 0 is leftmost column

	typedef enum logic [3:0] {
		DIGIT_0       = 4'd0,
		DIGIT_1       = 4'd1,
		DIGIT_2       = 4'd2,
		DIGIT_3       = 4'd3,
		DIGIT_4       = 4'd4,
		DIGIT_5       = 4'd5,
		DIGIT_6       = 4'd6,
		DIGIT_7       = 4'd7,
		DIGIT_8       = 4'd8,
		DIGIT_9       = 4'd9,
		GLYPH_V       = 4'd10,
		GLYPH_P_LOWER = 4'd11,
		GLYPH_COLON   = 4'd12,
		GLYPH_M_LOWER = 4'd13,
		GLYPH_BLANK   = 4'd14
	} glyph_code_t;

	function automatic glyph_t glyph_bits(input glyph_code_t code);
		case (code)
			DIGIT_0:       glyph_bits = {8'h00, 8'h3E, 8'h51, 8'h49, 8'h45, 8'h3E};
			DIGIT_1:       glyph_bits = {8'h00, 8'h00, 8'h42, 8'h7F, 8'h40, 8'h00};
			DIGIT_2:       glyph_bits = {8'h00, 8'h42, 8'h61, 8'h51, 8'h49, 8'h46};
			DIGIT_3:       glyph_bits = {8'h00, 8'h21, 8'h41, 8'h45, 8'h4B, 8'h31};
			DIGIT_4:       glyph_bits = {8'h00, 8'h18, 8'h14, 8'h12, 8'h7F, 8'h10};
			DIGIT_5:       glyph_bits = {8'h00, 8'h27, 8'h45, 8'h45, 8'h45, 8'h39};
			DIGIT_6:       glyph_bits = {8'h00, 8'h3C, 8'h4A, 8'h49, 8'h49, 8'h30};
			DIGIT_7:       glyph_bits = {8'h00, 8'h01, 8'h71, 8'h09, 8'h05, 8'h03};
			DIGIT_8:       glyph_bits = {8'h00, 8'h36, 8'h49, 8'h49, 8'h49, 8'h36};
			DIGIT_9:       glyph_bits = {8'h00, 8'h06, 8'h49, 8'h49, 8'h29, 8'h1E};
			GLYPH_V:       glyph_bits = {8'h00, 8'h1F, 8'h20, 8'h40, 8'h20, 8'h1F};
			GLYPH_P_LOWER: glyph_bits = {8'h00, 8'hFC, 8'h24, 8'h24, 8'h24, 8'h18};
			GLYPH_COLON:   glyph_bits = {8'h00, 8'h00, 8'h36, 8'h36, 8'h00, 8'h00};
			GLYPH_M_LOWER: glyph_bits = {8'h00, 8'h7C, 8'h04, 8'h18, 8'h04, 8'h78};
			default:       glyph_bits = '0;	// blank
		endcase
	endfunction

	// non-decimal nibbles show as a blank cell
	function automatic glyph_code_t digit_glyph(input logic [3:0] nibble);
		if (nibble > 4'd9)
			digit_glyph = GLYPH_BLANK;
		else
			digit_glyph = glyph_code_t'(nibble);
	endfunction

	function automatic glyph_code_t text_glyph_at(input logic [3:0] pos,
		input logic [19:0] digits);
		case (pos)
			4'd0:    text_glyph_at = GLYPH_V;
			4'd1:    text_glyph_at = GLYPH_P_LOWER;
			4'd2:    text_glyph_at = GLYPH_P_LOWER;
			4'd3:    text_glyph_at = GLYPH_COLON;
			4'd4:    text_glyph_at = digit_glyph(digits[19:16]);	// most significant
			4'd5:    text_glyph_at = digit_glyph(digits[15:12]);
			4'd6:    text_glyph_at = digit_glyph(digits[11:8]);
			4'd7:    text_glyph_at = digit_glyph(digits[7:4]);
			4'd8:    text_glyph_at = digit_glyph(digits[3:0]);
			4'd9:    text_glyph_at = GLYPH_M_LOWER;
			4'd10:   text_glyph_at = GLYPH_V;
			default: text_glyph_at = GLYPH_BLANK;
		endcase
	endfunction

endpackage

// File: hw/oled_link_pkg.sv
/*
 * Link-level definitions for the OLED serial path: byte kinds, sequencer
 * states, panel geometry and the fixed controller init command table.
 */
package oled_link_pkg;

	typedef enum logic {
		KIND_CMD  = 1'b0,	// drives D/C low
		KIND_DATA = 1'b1
	} byte_kind_t;

	typedef enum logic [2:0] {
		RESET_PULSE,
		INIT_CMDS,
		CLEAR_ADDR,
		CLEAR_DATA,
		TEXT_ADDR,
		TEXT_DATA
	} seq_state_t;

	localparam int INIT_CMD_COUNT = 30;
	localparam int PAGE_COUNT     = 4;
	localparam int PAGE_COLUMNS   = 128;
	localparam int ADDR_CMD_COUNT = 3;	// page, col low, col high
	localparam int TEXT_PAGE      = 0;

	// controller bring-up sequence, tail filled with no-ops
	function automatic logic [7:0] init_cmd_byte(input int idx);
		case (idx)
			0:  init_cmd_byte = 8'hAE;	// display off
			1:  init_cmd_byte = 8'h00;
			2:  init_cmd_byte = 8'h10;
			3:  init_cmd_byte = 8'h00;
			4:  init_cmd_byte = 8'hB0;
			5:  init_cmd_byte = 8'h81;	// contrast
			6:  init_cmd_byte = 8'hFF;
			7:  init_cmd_byte = 8'hA1;	// segment remap
			8:  init_cmd_byte = 8'hA6;
			9:  init_cmd_byte = 8'hA8;	// mux ratio
			10: init_cmd_byte = 8'h1F;	// 32 rows
			11: init_cmd_byte = 8'hC8;
			12: init_cmd_byte = 8'hD3;
			13: init_cmd_byte = 8'h00;
			14: init_cmd_byte = 8'hD5;
			15: init_cmd_byte = 8'h80;
			16: init_cmd_byte = 8'hD9;
			17: init_cmd_byte = 8'h1F;
			18: init_cmd_byte = 8'hDA;
			19: init_cmd_byte = 8'h00;
			20: init_cmd_byte = 8'hDB;
			21: init_cmd_byte = 8'h40;
			22: init_cmd_byte = 8'h8D;	// charge pump
			23: init_cmd_byte = 8'h14;
			24: init_cmd_byte = 8'hAF;	// display on
			default: init_cmd_byte = 8'hE3;
		endcase
	endfunction

endpackage
